//--- common/llc_cfg.svh
// LLC slice configuration
// Address and data widths, tag store geometry, DDR4 field split and DRAM waits
`ifndef LLC_CFG_SVH
`define LLC_CFG_SVH

// Word-addressed physical space
`define LLC_PADDR_BITS 19
`define LLC_DATA_W 64

// Direct-mapped tag store, 64 lines of one word each
`define LLC_INDEX_BITS 6

// DDR4 address split from low to high: column, bank, bank group, row
`define DDR4_COL_BITS 4
`define DDR4_BA_BITS 2
`define DDR4_BG_BITS 2
`define DDR4_ROW_BITS 11
`define DDR4_ADDR_W 17   // DIMM address pins

// DRAM waits in clock cycles
`define DDR4_ACT_LATENCY 8
`define DDR4_CAS_LATENCY 22
`define DDR4_PRE_LATENCY 5

`endif

//--- common/llc_pkg.sv
// LLC shared types
// Controller FSM state, DRAM commands and the DIMM command word
`default_nettype none

`include "llc_cfg.svh"

package llc_pkg;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_CHECK_HIT,
        ST_DRAM_READ,
        ST_WAIT_READ,
        ST_FILL,
        ST_DRAM_WRITE,
        ST_WAIT_WRITE,
        ST_RESPOND,
        ST_FLUSH
    } llc_state_t;

    typedef enum logic [2:0] {
        CMD_READ      = 3'b000,
        CMD_WRITE     = 3'b001,
        CMD_ACTIVATE  = 3'b010,
        CMD_PRECHARGE = 3'b011,
        CMD_NONE      = 3'b111   // DIMM deselected
    } dram_cmd_t;

    // ACTIVATE carries the row on the address pins
    typedef struct packed {
        logic [`DDR4_ADDR_W-`DDR4_ROW_BITS-1:0]   pad;
        logic [`DDR4_ROW_BITS-1:0]                row;
    } dram_row_view_t;

    // Every other command puts RAS/CAS/WE on the top pins
    typedef struct packed {
        logic                                     ras;
        logic                                     cas;
        logic                                     we;
        logic [`DDR4_ADDR_W-3-`DDR4_COL_BITS-1:0] pad;
        logic [`DDR4_COL_BITS-1:0]                col;
    } dram_cmd_view_t;

    typedef union packed {
        dram_row_view_t act;
        dram_cmd_view_t cmd;
    } dram_addr_t;

endpackage

`default_nettype wire

//--- llc/llc_tag_store.sv
// LLC tag store
// Direct-mapped valid/tag/data array, one word per line, registered lookup
`default_nettype none

`include "llc_cfg.svh"

module llc_tag_store (
    input  logic                       clk_in,
    input  logic                       rst_N_in,
    input  logic                       lookup,
    input  logic [`LLC_PADDR_BITS-1:0] lookup_addr,
    input  logic                       fill,
    input  logic [`LLC_PADDR_BITS-1:0] fill_addr,
    input  logic [`LLC_DATA_W-1:0]     fill_data,
    input  logic                       update,       // Write hit, uses fill_addr/fill_data
    input  logic                       invalidate_all,
    output logic                       hit,
    output logic [`LLC_DATA_W-1:0]     hit_data
);

    localparam int TAG_W = `LLC_PADDR_BITS - `LLC_INDEX_BITS;
    localparam int LINES = 1 << `LLC_INDEX_BITS;

    logic [LINES-1:0]       valid_q;
    logic [TAG_W-1:0]       tag_mem  [LINES];
    logic [`LLC_DATA_W-1:0] data_mem [LINES];

    // Index is the low address bits, tag the rest
    logic [`LLC_INDEX_BITS-1:0] lk_idx, wr_idx;
    logic [TAG_W-1:0]           lk_tag, wr_tag;
    logic                       wr_match;

    assign lk_idx   = lookup_addr[`LLC_INDEX_BITS-1:0];
    assign lk_tag   = lookup_addr[`LLC_PADDR_BITS-1:`LLC_INDEX_BITS];
    assign wr_idx   = fill_addr[`LLC_INDEX_BITS-1:0];
    assign wr_tag   = fill_addr[`LLC_PADDR_BITS-1:`LLC_INDEX_BITS];
    assign wr_match = valid_q[wr_idx] && (tag_mem[wr_idx] == wr_tag);

    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            valid_q <= '0;
            hit     <= 1'b0;
        end else begin
            if (invalidate_all) valid_q <= '0;          // Flush, nothing is dirty
            else if (fill)      valid_q[wr_idx] <= 1'b1;
            if (lookup)
                hit <= valid_q[lk_idx] && (tag_mem[lk_idx] == lk_tag);
        end
    end

    // Arrays and read data
    always_ff @(posedge clk_in) begin
        if (fill) begin
            tag_mem[wr_idx]  <= wr_tag;
            data_mem[wr_idx] <= fill_data;
        end else if (update && wr_match) begin
            data_mem[wr_idx] <= fill_data;              // Tag untouched on a write hit
        end
        if (lookup) hit_data <= data_mem[lk_idx];
    end

    // Controller never installs and updates together
    a_fill_update_excl: assert property (@(posedge clk_in) disable iff (!rst_N_in)
        !(fill && update));

endmodule

`default_nettype wire

//--- llc/llc_ctrl.sv
// LLC controller
// One request at a time, hit check, read-miss fill, write-through to DRAM
`default_nettype none

`include "llc_cfg.svh"

module llc_ctrl
    import llc_pkg::*;
(
    input  logic                       clk_in,
    input  logic                       rst_N_in,
    input  logic                       cs_in,
    input  logic                       flush_in,
    input  logic                       hc_valid_in,
    input  logic                       hc_we_in,
    input  logic [`LLC_PADDR_BITS-1:0] hc_addr_in,
    input  logic [`LLC_DATA_W-1:0]     hc_value_in,
    input  logic                       hc_ready_in,
    input  logic                       hit,
    input  logic [`LLC_DATA_W-1:0]     hit_data,
    input  logic                       mem_done,
    input  logic [`LLC_DATA_W-1:0]     mem_rdata,
    output logic                       hc_ready_out,
    output logic                       hc_valid_out,
    output logic [`LLC_PADDR_BITS-1:0] hc_addr_out,
    output logic [`LLC_DATA_W-1:0]     hc_value_out,
    output logic                       lookup,
    output logic [`LLC_PADDR_BITS-1:0] lookup_addr,
    output logic                       fill,
    output logic [`LLC_PADDR_BITS-1:0] fill_addr,
    output logic [`LLC_DATA_W-1:0]     fill_data,
    output logic                       update,
    output logic                       invalidate_all,
    output logic                       mem_req,
    output logic                       mem_we,
    output logic [`LLC_PADDR_BITS-1:0] mem_addr,
    output logic [`LLC_DATA_W-1:0]     mem_wdata
);

    llc_state_t state, next_state;

    logic [`LLC_PADDR_BITS-1:0] req_addr;
    logic                       req_we;
    logic [`LLC_DATA_W-1:0]     line_q;    // Write data, later the read result
    logic                       accept;

    assign hc_ready_out = (state == ST_IDLE);
    assign accept       = hc_ready_out && hc_valid_in && cs_in;

    // Lookup starts in the accept cycle so hit is ready in CHECK_HIT
    assign lookup      = accept;
    assign lookup_addr = hc_addr_in;

    // ------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (accept)        next_state = ST_CHECK_HIT;
                else if (flush_in) next_state = ST_FLUSH;
            end
            ST_CHECK_HIT: begin
                if (req_we)   next_state = ST_DRAM_WRITE;   // Every write goes through
                else if (hit) next_state = ST_RESPOND;
                else          next_state = ST_DRAM_READ;
            end
            ST_DRAM_READ:  next_state = ST_WAIT_READ;
            ST_WAIT_READ:  if (mem_done) next_state = ST_FILL;
            ST_FILL:       next_state = ST_RESPOND;
            ST_DRAM_WRITE: next_state = ST_WAIT_WRITE;
            ST_WAIT_WRITE: if (mem_done) next_state = ST_RESPOND;
            ST_RESPOND:    if (hc_valid_out && hc_ready_in) next_state = ST_IDLE;
            ST_FLUSH:      next_state = ST_IDLE;
            default:       next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            state        <= ST_IDLE;
            hc_valid_out <= 1'b0;
        end else begin
            state <= next_state;
            if (state == ST_RESPOND && !hc_valid_out)
                hc_valid_out <= 1'b1;
            else if (hc_valid_out && hc_ready_in)
                hc_valid_out <= 1'b0;              // Taken by the upper cache
        end
    end

    // Request payload
    always_ff @(posedge clk_in) begin
        if (accept) begin
            req_addr <= hc_addr_in;
            req_we   <= hc_we_in;
            line_q   <= hc_value_in;
        end else if (state == ST_CHECK_HIT && !req_we && hit) begin
            line_q   <= hit_data;
        end else if (state == ST_WAIT_READ && mem_done) begin
            line_q   <= mem_rdata;
        end
    end

    // ------------------------------------------------------------
    // Tag store and DRAM strobes
    // ------------------------------------------------------------
    assign fill           = (state == ST_FILL);
    assign fill_addr      = req_addr;
    assign fill_data      = line_q;
    assign update         = (state == ST_DRAM_WRITE);   // Store ignores it on a miss
    assign invalidate_all = (state == ST_FLUSH);

    assign mem_req   = (state == ST_DRAM_READ) || (state == ST_DRAM_WRITE);
    assign mem_we    = req_we;
    assign mem_addr  = req_addr;
    assign mem_wdata = line_q;

    assign hc_addr_out  = req_addr;
    assign hc_value_out = line_q;

    // Response holds under back-pressure
    a_resp_hold: assert property (@(posedge clk_in) disable iff (!rst_N_in)
        hc_valid_out && !hc_ready_in |=> hc_valid_out && $stable(hc_value_out));

    // Only one DRAM access in flight
    a_one_mem_req: assert property (@(posedge clk_in) disable iff (!rst_N_in)
        mem_req |=> !mem_req throughout mem_done[->1]);

endmodule

`default_nettype wire

//--- ddr4/ddr4_cmd_sequencer.sv
// DDR4 command sequencer
// Closed-page ACTIVATE, READ/WRITE, PRECHARGE with fixed waits, one beat per access
`default_nettype none

`include "llc_cfg.svh"

module ddr4_cmd_sequencer
    import llc_pkg::*;
(
    input  logic                       clk_in,
    input  logic                       rst_N_in,
    input  logic                       mem_req,
    input  logic                       mem_we,
    input  logic [`LLC_PADDR_BITS-1:0] mem_addr,
    input  logic [`LLC_DATA_W-1:0]     mem_wdata,
    input  logic [`LLC_DATA_W-1:0]     dq_in,
    output logic                       mem_done,
    output logic [`LLC_DATA_W-1:0]     mem_rdata,
    output logic                       dram_cs_n_out,
    output logic                       act_n_out,
    output dram_addr_t                 dram_addr_out,
    output logic [`DDR4_BG_BITS-1:0]   bg_out,
    output logic [`DDR4_BA_BITS-1:0]   ba_out,
    output logic [`LLC_DATA_W-1:0]     dq_out,
    output logic                       dq_oe_out
);

    localparam int BA_LSB = `DDR4_COL_BITS;
    localparam int BG_LSB = BA_LSB + `DDR4_BA_BITS;
    localparam int RW_LSB = BG_LSB + `DDR4_BG_BITS;
    localparam int CNT_W  = $clog2(`DDR4_CAS_LATENCY + 1);

    typedef enum logic [2:0] {
        S_IDLE, S_ACT, S_ACT_WAIT, S_RW, S_CAS_WAIT, S_PRE, S_PRE_WAIT
    } seq_state_t;

    seq_state_t                 state;
    logic [CNT_W-1:0]           cnt;      // Shared wait counter
    logic [`LLC_PADDR_BITS-1:0] addr_q;
    logic                       we_q;
    logic [`LLC_DATA_W-1:0]     wdata_q;
    logic [`LLC_DATA_W-1:0]     rdata_q;
    dram_cmd_t                  cmd;

    // ------------------------------------------------------------
    // Each wait state leaves when cnt reaches 0
    // ------------------------------------------------------------
    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: if (mem_req) state <= S_ACT;
                S_ACT: begin
                    cnt   <= CNT_W'(`DDR4_ACT_LATENCY - 2);   // RW lands ACT_LATENCY later
                    state <= S_ACT_WAIT;
                end
                S_ACT_WAIT: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == '0) state <= S_RW;
                end
                S_RW: begin
                    cnt   <= CNT_W'(`DDR4_CAS_LATENCY - 1);   // Last wait cycle is the data beat
                    state <= we_q ? S_PRE : S_CAS_WAIT;        // Write beat is the RW cycle
                end
                S_CAS_WAIT: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == '0) state <= S_PRE;
                end
                S_PRE: begin
                    cnt   <= CNT_W'(`DDR4_PRE_LATENCY - 1);   // mem_done on last wait cycle
                    state <= S_PRE_WAIT;
                end
                S_PRE_WAIT: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == '0) state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Request latch and read beat capture
    always_ff @(posedge clk_in) begin
        if (state == S_IDLE && mem_req) begin
            addr_q  <= mem_addr;
            we_q    <= mem_we;
            wdata_q <= mem_wdata;
        end
        if (state == S_CAS_WAIT && cnt == '0) rdata_q <= dq_in;
    end

    assign mem_done  = (state == S_PRE_WAIT) && (cnt == '0);
    assign mem_rdata = rdata_q;

    // ------------------------------------------------------------
    // Command encoding
    // ------------------------------------------------------------
    always_comb begin
        case (state)
            S_ACT:   cmd = CMD_ACTIVATE;
            S_RW:    cmd = we_q ? CMD_WRITE : CMD_READ;
            S_PRE:   cmd = CMD_PRECHARGE;
            default: cmd = CMD_NONE;
        endcase
    end

    always_comb begin
        dram_addr_out = '0;
        if (cmd == CMD_ACTIVATE) begin
            dram_addr_out.act.row = addr_q[RW_LSB +: `DDR4_ROW_BITS];
        end else begin
            dram_addr_out.cmd.col = addr_q[`DDR4_COL_BITS-1:0];
            case (cmd)
                CMD_READ:      {dram_addr_out.cmd.ras, dram_addr_out.cmd.cas,
                                dram_addr_out.cmd.we} = 3'b101;
                CMD_WRITE:     {dram_addr_out.cmd.ras, dram_addr_out.cmd.cas,
                                dram_addr_out.cmd.we} = 3'b100;
                CMD_PRECHARGE: {dram_addr_out.cmd.ras, dram_addr_out.cmd.cas,
                                dram_addr_out.cmd.we} = 3'b010;
                default:       {dram_addr_out.cmd.ras, dram_addr_out.cmd.cas,
                                dram_addr_out.cmd.we} = 3'b111;   // NOP
            endcase
        end
    end

    assign dram_cs_n_out = (cmd == CMD_NONE);      // Deselect between commands
    assign act_n_out     = (cmd != CMD_ACTIVATE);
    assign bg_out        = addr_q[BG_LSB +: `DDR4_BG_BITS];
    assign ba_out        = addr_q[BA_LSB +: `DDR4_BA_BITS];
    assign dq_out        = wdata_q;
    assign dq_oe_out     = (cmd == CMD_WRITE);

    // Bus driven only while the pins carry WRITE and released as PRECHARGE goes out
    a_dq_write_only: assert property (@(posedge clk_in) disable iff (!rst_N_in)
        dq_oe_out |-> ({dram_addr_out.cmd.ras, dram_addr_out.cmd.cas,
                        dram_addr_out.cmd.we} == 3'b100)
                      ##1 (!dq_oe_out && cmd == CMD_PRECHARGE));

endmodule

`default_nettype wire

//--- rtl/last_level_cache.sv
// Last-level cache slice top
// Write-through, no-write-allocate LLC over a closed-page DDR4 command path
`default_nettype none

`include "llc_cfg.svh"

module last_level_cache
    import llc_pkg::*;
(
    input  logic                       clk_in,
    input  logic                       rst_N_in,
    input  logic                       cs_in,
    input  logic                       flush_in,
    // Higher-level cache
    input  logic                       hc_valid_in,
    input  logic                       hc_we_in,
    input  logic [`LLC_PADDR_BITS-1:0] hc_addr_in,
    input  logic [`LLC_DATA_W-1:0]     hc_value_in,
    input  logic                       hc_ready_in,
    output logic                       hc_ready_out,
    output logic                       hc_valid_out,
    output logic [`LLC_PADDR_BITS-1:0] hc_addr_out,
    output logic [`LLC_DATA_W-1:0]     hc_value_out,
    // DIMM
    output logic                       dram_cs_n_out,
    output logic                       act_n_out,
    output dram_addr_t                 dram_addr_out,
    output logic [`DDR4_BG_BITS-1:0]   bg_out,
    output logic [`DDR4_BA_BITS-1:0]   ba_out,
    output logic [`LLC_DATA_W-1:0]     dq_out,
    output logic                       dq_oe_out,
    input  logic [`LLC_DATA_W-1:0]     dq_in
);

    logic                       lookup, fill, update, invalidate_all, hit;
    logic [`LLC_PADDR_BITS-1:0] lookup_addr, fill_addr;
    logic [`LLC_DATA_W-1:0]     fill_data, hit_data;
    logic                       mem_req, mem_we, mem_done;
    logic [`LLC_PADDR_BITS-1:0] mem_addr;
    logic [`LLC_DATA_W-1:0]     mem_wdata, mem_rdata;

    llc_ctrl i_ctrl (
        .clk_in, .rst_N_in, .cs_in, .flush_in,
        .hc_valid_in, .hc_we_in, .hc_addr_in, .hc_value_in, .hc_ready_in,
        .hit, .hit_data, .mem_done, .mem_rdata,
        .hc_ready_out, .hc_valid_out, .hc_addr_out, .hc_value_out,
        .lookup, .lookup_addr, .fill, .fill_addr, .fill_data, .update, .invalidate_all,
        .mem_req, .mem_we, .mem_addr, .mem_wdata
    );

    llc_tag_store i_tag_store (
        .clk_in, .rst_N_in, .lookup, .lookup_addr, .fill, .fill_addr, .fill_data,
        .update, .invalidate_all, .hit, .hit_data
    );

    ddr4_cmd_sequencer i_seq (
        .clk_in, .rst_N_in, .mem_req, .mem_we, .mem_addr, .mem_wdata, .dq_in,
        .mem_done, .mem_rdata, .dram_cs_n_out, .act_n_out, .dram_addr_out,
        .bg_out, .ba_out, .dq_out, .dq_oe_out
    );

endmodule

`default_nettype wire

//--- verification/ddr4_dimm_model.sv
// DDR4 DIMM behavioral model
// Decodes closed-page commands, stores WRITE beats and returns READ beats after CAS latency
`default_nettype none

`include "llc_cfg.svh"

module ddr4_dimm_model
    import llc_pkg::*;
(
    input  logic                     clk_in,
    input  logic                     rst_N_in,
    input  logic                     cs_n,
    input  logic                     act_n,
    input  dram_addr_t               addr,
    input  logic [`DDR4_BG_BITS-1:0] bg,
    input  logic [`DDR4_BA_BITS-1:0] ba,
    input  logic [`LLC_DATA_W-1:0]   wdata,
    input  logic                     wdata_oe,
    output logic [`LLC_DATA_W-1:0]   rdata,
    output int unsigned              act_count    // ACTIVATEs seen since reset
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WORDS = 1 << `LLC_PADDR_BITS;

    logic [`LLC_DATA_W-1:0]     mem [WORDS];
    logic [`DDR4_ROW_BITS-1:0]  open_row;        // Latched at ACTIVATE
    logic [`LLC_PADDR_BITS-1:0] word_addr;
    logic [`LLC_DATA_W-1:0]     rd_word;
    int                         rd_cnt;          // Cycles left to the read beat

    // Row from ACTIVATE, the rest from the current command
    assign word_addr = {open_row, bg, ba, addr.cmd.col};

    // Each word starts as its own address under a fixed top pattern
    initial begin
        for (int a = 0; a < WORDS; a++) begin
            mem[a] = {{(`LLC_DATA_W-`LLC_PADDR_BITS){1'b0}}, a[`LLC_PADDR_BITS-1:0]}
                     ^ 64'hA5A5_0000_0000_0000;
        end
    end

    always @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            act_count <= 0;
            rd_cnt    <= 0;
            rdata     <= '0;
            open_row  <= '0;
        end else begin
            rdata <= '0;                         // Bus idle outside the data beat
            if (rd_cnt != 0) begin
                rd_cnt <= rd_cnt - 1;
                if (rd_cnt == 1) rdata <= rd_word;   // Valid CAS_LATENCY cycles after READ
            end
            if (!cs_n) begin
                if (!act_n) begin
                    open_row  <= addr.act.row;
                    act_count <= act_count + 1;
                end else begin
                    case ({addr.cmd.ras, addr.cmd.cas, addr.cmd.we})
                        3'b101: begin                // READ
                            rd_word <= mem[word_addr];
                            rd_cnt  <= `DDR4_CAS_LATENCY - 1;
                        end
                        3'b100: if (wdata_oe) mem[word_addr] <= wdata;   // WRITE
                        default: ;                   // PRECHARGE closes the row
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_last_level_cache.sv
// Last-level cache testbench
// File-driven requests under random back-pressure, checked against the DIMM model
`default_nettype none

`include "llc_cfg.svh"

module tb_last_level_cache
    import llc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 200;     // Cycles, one DRAM access takes about 40

    logic                       clk_in;
    logic                       rst_N_in;
    logic                       cs_in, flush_in;
    logic                       hc_valid_in, hc_we_in, hc_ready_in;
    logic [`LLC_PADDR_BITS-1:0] hc_addr_in, hc_addr_out;
    logic [`LLC_DATA_W-1:0]     hc_value_in, hc_value_out;
    logic                       hc_ready_out, hc_valid_out;
    logic                       dram_cs_n, act_n, dq_oe;
    dram_addr_t                 dram_addr;
    logic [`DDR4_BG_BITS-1:0]   bg;
    logic [`DDR4_BA_BITS-1:0]   ba;
    logic [`LLC_DATA_W-1:0]     dq_out, dq_in;
    int unsigned                act_count;

    int tests, failed, errors;
    int test_errs;                       // Errors in the running test
    bit abort;                           // Set on a timeout, stops the run

    last_level_cache i_dut (
        .clk_in, .rst_N_in, .cs_in, .flush_in,
        .hc_valid_in, .hc_we_in, .hc_addr_in, .hc_value_in, .hc_ready_in,
        .hc_ready_out, .hc_valid_out, .hc_addr_out, .hc_value_out,
        .dram_cs_n_out(dram_cs_n), .act_n_out(act_n), .dram_addr_out(dram_addr),
        .bg_out(bg), .ba_out(ba), .dq_out(dq_out), .dq_oe_out(dq_oe), .dq_in(dq_in)
    );

    ddr4_dimm_model i_dimm (
        .clk_in, .rst_N_in, .cs_n(dram_cs_n), .act_n(act_n), .addr(dram_addr),
        .bg, .ba, .wdata(dq_out), .wdata_oe(dq_oe), .rdata(dq_in), .act_count
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;    // 100 ns period
    end

    // ------------------------------------------------------------
    // Request helpers
    // ------------------------------------------------------------
    task automatic wait_idle(input string name, output bit ok);
        int cycles;
        cycles = 0;
        ok     = 1'b0;
        while (!ok && cycles < WAIT_LIMIT) begin
            @(negedge clk_in);           // Sample mid-cycle
            ok = hc_ready_out;
            cycles++;
        end
        if (!ok) begin
            $display("%s: timeout waiting for hc_ready_out", name);
            test_errs++;
            abort = 1'b1;
        end
    endtask

    task automatic issue_request(input string name, input bit we,
                                 input logic [`LLC_PADDR_BITS-1:0] addr,
                                 input logic [`LLC_DATA_W-1:0] wdata,
                                 input logic [`LLC_DATA_W-1:0] exp_data,
                                 input int unsigned exp_act);
        int unsigned                act_before, act_after;
        logic [`LLC_DATA_W-1:0]     held;
        logic [`LLC_PADDR_BITS-1:0] held_addr;
        bit                         seen, done, ok;
        int                         cycles;
        act_before = act_count;
        act_after  = act_count;
        held       = '0;
        held_addr  = '0;
        seen       = 1'b0;
        done       = 1'b0;
        cycles     = 0;
        wait_idle(name, ok);
        if (ok) begin
            @(posedge clk_in);
            hc_valid_in <= 1'b1;
            hc_we_in    <= we;
            hc_addr_in  <= addr;
            hc_value_in <= wdata;
            @(posedge clk_in);           // Accepted here, FSM was idle
            hc_valid_in <= 1'b0;
            while (!done && cycles < WAIT_LIMIT) begin
                @(posedge clk_in);
                hc_ready_in <= ($urandom % 3) != 0;   // Stall about a third of cycles
                @(negedge clk_in);
                cycles++;
                if (hc_valid_out) begin
                    if (!seen) begin
                        held      = hc_value_out;
                        held_addr = hc_addr_out;
                    end else if (hc_value_out != held) begin
                        $display("Fail %s stall hold: expected %h actual %h",
                                 name, held, hc_value_out);
                        test_errs++;
                    end
                    seen      = 1'b1;
                    done      = hc_ready_in;  // Handshake at the next edge
                    act_after = act_count;
                end else if (seen) begin
                    $display("%s: hc_valid_out dropped before hc_ready_in", name);
                    test_errs++;
                end
            end
            if (!done) begin
                $display("%s: timeout waiting for hc_valid_out", name);
                test_errs++;
                abort = 1'b1;
            end else begin
                @(posedge clk_in);       // Response taken at this edge
                hc_ready_in <= 1'b0;
                if (!we && held != exp_data) begin
                    $display("Fail %s data: expected %h actual %h", name, exp_data, held);
                    test_errs++;
                end
                if (held_addr != addr) begin
                    $display("Fail %s addr: expected %h actual %h", name, addr, held_addr);
                    test_errs++;
                end
                // Write-through lands in the DIMM
                if (we && i_dimm.mem[addr] != wdata) begin
                    $display("Fail %s dram word: expected %h actual %h",
                             name, wdata, i_dimm.mem[addr]);
                    test_errs++;
                end
                if (act_after - act_before != exp_act) begin
                    $display("Fail %s activates: expected %0d actual %0d",
                             name, exp_act, act_after - act_before);
                    test_errs++;
                end
            end
        end
    endtask

    task automatic apply_flush(input string name);
        int unsigned act_before;
        bit          ok;
        act_before = act_count;
        wait_idle(name, ok);
        if (ok) begin
            @(posedge clk_in);
            flush_in <= 1'b1;
            @(posedge clk_in);           // Sampled in idle
            flush_in <= 1'b0;
            @(negedge clk_in);
            if (hc_ready_out) begin
                $display("%s: hc_ready_out stayed high in the flush cycle", name);
                test_errs++;
            end
            @(negedge clk_in);
            if (!hc_ready_out) begin
                $display("%s: hc_ready_out did not return one cycle after flush", name);
                test_errs++;
            end
            if (act_count != act_before) begin
                $display("Fail %s activates: expected 0 actual %0d",
                         name, act_count - act_before);
                test_errs++;
            end
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        if (test_errs == 0) begin
            $display("%-24s passed", name);
        end else begin
            failed++;
            $display("%-24s failed with %0d errors", name, test_errs);
        end
        errors    += test_errs;
        test_errs  = 0;
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        string                      line, name;
        logic [7:0]                 op;
        logic [`LLC_PADDR_BITS-1:0] addr;
        logic [`LLC_DATA_W-1:0]     wdata, exp_data;
        int unsigned                exp_act;
        int                         fd, n, line_no;

        void'($urandom(32'h0ffa6b98));
        rst_N_in    = 1'b0;
        cs_in       = 1'b0;
        flush_in    = 1'b0;
        hc_valid_in = 1'b0;
        hc_we_in    = 1'b0;
        hc_addr_in  = '0;
        hc_value_in = '0;
        hc_ready_in = 1'b0;
        tests       = 0;
        failed      = 0;
        errors      = 0;
        test_errs   = 0;
        abort       = 1'b0;
        line_no     = 0;

        repeat (7) @(posedge clk_in);
        @(negedge clk_in);
        // valid, dq_oe, cs_n, ready
        if ({hc_valid_out, dq_oe, dram_cs_n, hc_ready_out} != 4'b0011) begin
            $display("Fail reset_values: expected %b actual %b", 4'b0011,
                     {hc_valid_out, dq_oe, dram_cs_n, hc_ready_out});
            test_errs++;
        end
        report_test("reset_values");
        @(posedge clk_in);               // Eighth edge in reset
        rst_N_in <= 1'b1;
        cs_in    <= 1'b1;

        fd = $fopen("verification/llc_test_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open verification/llc_test_input.txt");
            errors++;
        end else begin
            while (!abort && !$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                line_no++;
                if (line.len() < 3 || line.getc(0) == "#") continue;   // Blank or comment
                n = $sscanf(line, "%s %h %h %h %d", op, addr, wdata, exp_data, exp_act);
                if (n != 5) begin
                    $display("Line %0d of the input file cannot be parsed", line_no);
                    errors++;
                    continue;
                end
                name = $sformatf("L%0d_%s_%05h", line_no, op, addr);
                case (op)
                    "R":     issue_request(name, 1'b0, addr, wdata, exp_data, exp_act);
                    "W":     issue_request(name, 1'b1, addr, wdata, exp_data, exp_act);
                    "F":     apply_flush(name);
                    default: begin
                        $display("%s: unknown operation", name);
                        test_errs++;
                    end
                endcase
                report_test(name);
            end
            $fclose(fd);
        end

        $display("Tests %0d, passed %0d, failed %0d, errors %0d",
                 tests, tests - failed, failed, errors);
        if (errors == 0 && tests > 1)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/llc_test_input.txt
# op addr(hex word) wdata(hex) expected_rdata(hex) expected_activates(dec)
# R read, W write, F flush; wdata unused for R and F, expected_rdata unused for W and F
R 00123 0000000000000000 a5a5000000000123 1
R 00123 0000000000000000 a5a5000000000123 0
R 2a4c7 0000000000000000 a5a500000002a4c7 1
W 00123 1122334455667788 0000000000000000 1
R 00123 0000000000000000 1122334455667788 0
W 3fe05 cafef00d12345678 0000000000000000 1
R 3fe05 0000000000000000 cafef00d12345678 1
R 3fe05 0000000000000000 cafef00d12345678 0
R 7fff0 0000000000000000 a5a500000007fff0 1
F 00000 0000000000000000 0000000000000000 0
R 00123 0000000000000000 1122334455667788 1
R 7fff0 0000000000000000 a5a500000007fff0 1
R 7fff0 0000000000000000 a5a500000007fff0 0
R 40123 0000000000000000 a5a5000000040123 1
R 00123 0000000000000000 1122334455667788 1
W 40123 0f0f0f0f0f0f0f0f 0000000000000000 1
R 00123 0000000000000000 1122334455667788 0
R 40123 0000000000000000 0f0f0f0f0f0f0f0f 1

//--- last_level_cache.f
+incdir+common
common/llc_pkg.sv
llc/llc_tag_store.sv
llc/llc_ctrl.sv
ddr4/ddr4_cmd_sequencer.sv
rtl/last_level_cache.sv
verification/ddr4_dimm_model.sv
verification/tb_last_level_cache.sv

//--- Makefile
# Verilator build and run for the last-level cache slice
VERILATOR  ?= verilator
TOP        ?= tb_last_level_cache
RTL_TOP    ?= last_level_cache
FILELIST   ?= last_level_cache.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST OK" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
